/* src/pqs_pkg.sv */
package pqs_pkg;

    // ========================================================================
    // Switch geometry
    // ========================================================================
    localparam int DATA_WIDTH = 32;
    localparam int PORT_NUM   = 4;
    localparam int PORT_W     = 2;
    localparam int SLOT_NUM   = 8;
    localparam int SLOT_W     = 3;
    localparam int SLOT_WORDS = 8;      // Header plus up to 7 payload words
    localparam int WORD_W     = 3;
    localparam int LEN_W      = 3;
    localparam int TAG_W      = DATA_WIDTH - PORT_W - LEN_W;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // ========================================================================
    // Header word, seen either as raw data or as decoded fields
    // ========================================================================
    typedef union packed {
        data_t raw;
        struct packed {
            logic [PORT_W-1:0] dest;    // Output port
            logic [LEN_W-1:0]  len;     // Payload words, 1 to 7
            logic [TAG_W-1:0]  tag;     // Carried through untouched
        } hdr;
    } hdr_word_u;

endpackage

/* src/pkt_decode.sv */
module pkt_decode #(
    parameter  int P_SLOT_NUM = 8,
    localparam int SW         = $clog2(P_SLOT_NUM)
) (
    input  logic                       clk_in,
    input  logic                       rst_n_in,
    input  logic                       i_wr_vld,
    input  logic                       i_wr_sop,
    input  logic                       i_wr_eop,
    input  pqs_pkg::data_t             i_wr_data,
    input  logic                       i_alloc_ok,
    input  logic [SW-1:0]              i_alloc_slot,
    output logic                       o_alloc_req,
    output logic                       o_wr_en,
    output logic [SW-1:0]              o_wr_slot,
    output logic [pqs_pkg::WORD_W-1:0] o_wr_idx,
    output pqs_pkg::data_t             o_wr_data,
    output logic                       o_commit,
    output logic [SW-1:0]              o_commit_slot,
    output logic [pqs_pkg::PORT_W-1:0] o_commit_dest,
    output logic                       o_abort,
    output logic [SW-1:0]              o_abort_slot,
    output logic                       o_drop
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RECV = 2'd1;
    localparam logic [1:0] ST_DISC = 2'd2;

    pqs_pkg::hdr_word_u         hdr_in;
    logic [1:0]                 state_q;
    logic                       nofit_q;    // Discarding a packet that found no slot
    logic [SW-1:0]              slot_q;
    logic [pqs_pkg::PORT_W-1:0] dest_q;
    logic [pqs_pkg::LEN_W-1:0]  len_q;
    logic [pqs_pkg::LEN_W-1:0]  cnt_q;      // Payload words taken so far
    logic [pqs_pkg::LEN_W-1:0]  cnt_nxt;
    logic                       hdr_ok;
    logic                       frame_err;

    assign hdr_in  = i_wr_data;
    assign cnt_nxt = cnt_q + 1'b1;

    // A header needs a nonzero length and must not carry eop itself
    assign hdr_ok      = !i_wr_eop && (hdr_in.hdr.len != '0);
    assign o_alloc_req = i_wr_vld && i_wr_sop && hdr_ok && (state_q == ST_IDLE);

    // eop must land exactly on the length-th payload word
    assign frame_err = i_wr_sop || (i_wr_eop != (cnt_nxt == len_q));

    assign o_wr_slot     = slot_q;
    assign o_commit_slot = slot_q;
    assign o_commit_dest = dest_q;
    assign o_abort_slot  = slot_q;

    // ========================================================================
    // Framing FSM
    // ========================================================================
    always_ff @(posedge clk_in) begin
        if (!rst_n_in) begin
            state_q  <= ST_IDLE;
            nofit_q  <= 1'b0;
            o_wr_en  <= 1'b0;
            o_commit <= 1'b0;
            o_abort  <= 1'b0;
            o_drop   <= 1'b0;
        end else begin
            o_wr_en  <= 1'b0;
            o_commit <= 1'b0;
            o_abort  <= 1'b0;
            o_drop   <= 1'b0;
            if (i_wr_vld) begin
                case (state_q)
                    ST_IDLE: begin
                        if (o_alloc_req && i_alloc_ok) begin
                            o_wr_en <= 1'b1;        // Header goes to word 0
                            state_q <= ST_RECV;
                        end else if (o_alloc_req) begin
                            nofit_q <= 1'b1;        // Buffer full, drop at eop
                            state_q <= ST_DISC;
                        end else begin
                            o_drop <= 1'b1;         // Bad header or stray word
                        end
                    end
                    ST_RECV: begin
                        if (frame_err) begin
                            o_abort <= 1'b1;
                            o_drop  <= 1'b1;
                            state_q <= i_wr_eop ? ST_IDLE : ST_DISC;
                        end else begin
                            o_wr_en <= 1'b1;
                            if (i_wr_eop) begin
                                o_commit <= 1'b1;
                                state_q  <= ST_IDLE;
                            end
                        end
                    end
                    default: begin
                        if (i_wr_eop) begin
                            o_drop  <= nofit_q;     // Malformed ones already strobed
                            nofit_q <= 1'b0;
                            state_q <= ST_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (i_wr_vld) begin
            o_wr_data <= hdr_in.raw;
            o_wr_idx  <= (state_q == ST_IDLE) ? '0 : pqs_pkg::WORD_W'(cnt_nxt);
            cnt_q     <= (state_q == ST_IDLE) ? '0 : cnt_nxt;
        end
        if (o_alloc_req && i_alloc_ok) begin
            slot_q <= i_alloc_slot;
            dest_q <= hdr_in.hdr.dest;
            len_q  <= hdr_in.hdr.len;
        end
    end

    // Committed packet ends on the word index given by its header length
    a_commit_idx : assert property (@(posedge clk_in) disable iff (!rst_n_in)
        o_commit |-> (o_wr_idx == pqs_pkg::WORD_W'(len_q)));

endmodule

/* src/slot_buffer.sv */
module slot_buffer #(
    parameter  int P_PORT_NUM = 4,
    parameter  int P_SLOT_NUM = 8,
    localparam int SW         = $clog2(P_SLOT_NUM)
) (
    input  logic                       clk_in,
    input  logic                       rst_n_in,
    input  logic [P_PORT_NUM-1:0]      i_alloc_req,
    output logic [P_PORT_NUM-1:0]      o_alloc_ok,
    output logic [SW-1:0]              o_alloc_slot   [P_PORT_NUM-1:0],
    input  logic [P_PORT_NUM-1:0]      i_wr_en,
    input  logic [SW-1:0]              i_wr_slot      [P_PORT_NUM-1:0],
    input  logic [pqs_pkg::WORD_W-1:0] i_wr_idx       [P_PORT_NUM-1:0],
    input  pqs_pkg::data_t             i_wr_data      [P_PORT_NUM-1:0],
    input  logic [P_PORT_NUM-1:0]      i_commit,
    input  logic [SW-1:0]              i_commit_slot  [P_PORT_NUM-1:0],
    input  logic [pqs_pkg::PORT_W-1:0] i_commit_dest  [P_PORT_NUM-1:0],
    input  logic [P_PORT_NUM-1:0]      i_abort,
    input  logic [SW-1:0]              i_abort_slot   [P_PORT_NUM-1:0],
    output logic [P_PORT_NUM-1:0]      o_q_vld,
    output logic [SW-1:0]              o_q_slot       [P_PORT_NUM-1:0],
    input  logic [P_PORT_NUM-1:0]      i_q_pop,
    input  logic [SW-1:0]              i_rd_slot      [P_PORT_NUM-1:0],
    input  logic [pqs_pkg::WORD_W-1:0] i_rd_idx       [P_PORT_NUM-1:0],
    output pqs_pkg::data_t             o_rd_word      [P_PORT_NUM-1:0],
    input  logic [P_PORT_NUM-1:0]      i_release,
    input  logic [SW-1:0]              i_release_slot [P_PORT_NUM-1:0],
    output logic                       o_full
);

    localparam int QD = 1 << SW;

    pqs_pkg::data_t        mem [P_SLOT_NUM][pqs_pkg::SLOT_WORDS];
    logic [P_SLOT_NUM-1:0] busy_q;
    logic [P_SLOT_NUM-1:0] busy_d;

    // ========================================================================
    // Slot allocation and release
    // ========================================================================
    always_comb begin
        logic [P_SLOT_NUM-1:0] avail;
        avail = ~busy_q;
        for (int i = 0; i < P_PORT_NUM; i++) begin
            o_alloc_ok[i]   = 1'b0;
            o_alloc_slot[i] = '0;
            // Scan downward so the lowest free slot is the one kept
            for (int s = P_SLOT_NUM - 1; s >= 0; s--) begin
                if (i_alloc_req[i] && avail[s]) begin
                    o_alloc_ok[i]   = 1'b1;
                    o_alloc_slot[i] = SW'(s);
                end
            end
            if (o_alloc_ok[i]) begin
                avail[o_alloc_slot[i]] = 1'b0;
            end
        end
        busy_d = ~avail;
        for (int i = 0; i < P_PORT_NUM; i++) begin
            if (i_abort[i]) begin
                busy_d[i_abort_slot[i]] = 1'b0;
            end
            if (i_release[i]) begin
                busy_d[i_release_slot[i]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n_in) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    assign o_full = &busy_q;

    // Packet storage, each input writes only its own slot
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < P_PORT_NUM; i++) begin
            if (i_wr_en[i]) begin
                mem[i_wr_slot[i]][i_wr_idx[i]] <= i_wr_data[i];
            end
        end
    end

    // ========================================================================
    // Per-output descriptor queues and read ports
    // ========================================================================
    for (genvar o = 0; o < P_PORT_NUM; o++) begin : g_out
        logic [SW-1:0]         fifo    [QD];
        logic [SW-1:0]         wr_ptr;
        logic [SW-1:0]         rd_ptr;
        logic [SW:0]           cnt;
        logic [SW:0]           push_n;
        logic [P_PORT_NUM-1:0] push_hit;
        logic [SW-1:0]         push_at [P_PORT_NUM];

        // Same-cycle commits land in input order
        always_comb begin
            push_n = '0;
            for (int i = 0; i < P_PORT_NUM; i++) begin
                push_hit[i] = i_commit[i] && (int'(i_commit_dest[i]) == o);
                push_at[i]  = wr_ptr + push_n[SW-1:0];
                push_n      = push_n + {{SW{1'b0}}, push_hit[i]};
            end
        end

        always_ff @(posedge clk_in) begin
            for (int i = 0; i < P_PORT_NUM; i++) begin
                if (push_hit[i]) begin
                    fifo[push_at[i]] <= i_commit_slot[i];
                end
            end
        end

        always_ff @(posedge clk_in) begin
            if (!rst_n_in) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                cnt    <= '0;
            end else begin
                wr_ptr <= wr_ptr + push_n[SW-1:0];
                rd_ptr <= rd_ptr + {{(SW-1){1'b0}}, i_q_pop[o]};
                cnt    <= cnt + push_n - {{SW{1'b0}}, i_q_pop[o]};
            end
        end

        assign o_q_vld[o]   = (cnt != '0);
        assign o_q_slot[o]  = fifo[rd_ptr];
        assign o_rd_word[o] = mem[i_rd_slot[o]][i_rd_idx[o]];

        a_pop_empty : assert property (@(posedge clk_in) disable iff (!rst_n_in)
            i_q_pop[o] |-> o_q_vld[o]);
        a_release_free : assert property (@(posedge clk_in) disable iff (!rst_n_in)
            i_release[o] |-> busy_q[i_release_slot[o]]);
        a_abort_free : assert property (@(posedge clk_in) disable iff (!rst_n_in)
            i_abort[o] |-> busy_q[i_abort_slot[o]]);    // Input of the same index
    end

endmodule

/* src/port_output.sv */
module port_output #(
    parameter  int P_SLOT_NUM = 8,
    localparam int SW         = $clog2(P_SLOT_NUM)
) (
    input  logic                       clk_in,
    input  logic                       rst_n_in,
    input  logic                       i_q_vld,
    input  logic [SW-1:0]              i_q_slot,
    input  pqs_pkg::data_t             i_rd_word,
    output logic                       o_q_pop,
    output logic [SW-1:0]              o_rd_slot,
    output logic [pqs_pkg::WORD_W-1:0] o_rd_idx,
    output logic                       o_release,
    output logic [SW-1:0]              o_release_slot,
    output logic                       o_rd_vld,
    output logic                       o_rd_sop,
    output logic                       o_rd_eop,
    output pqs_pkg::data_t             o_rd_data
);

    pqs_pkg::hdr_word_u         rd_hdr;
    logic                       sending_q;
    logic [SW-1:0]              slot_q;
    logic [pqs_pkg::WORD_W-1:0] idx_q;      // Next word of the slot to read
    logic [pqs_pkg::LEN_W-1:0]  len_q;
    logic                       last_word;

    assign rd_hdr  = i_rd_word;
    assign o_q_pop = !sending_q && i_q_vld;

    // Idle reads the header of the queue head straight away
    assign o_rd_slot = sending_q ? slot_q : i_q_slot;
    assign o_rd_idx  = sending_q ? idx_q : '0;

    assign last_word      = sending_q && (idx_q == pqs_pkg::WORD_W'(len_q));
    assign o_release      = last_word;
    assign o_release_slot = slot_q;

    always_ff @(posedge clk_in) begin
        if (!rst_n_in) begin
            sending_q <= 1'b0;
            o_rd_vld  <= 1'b0;
            o_rd_sop  <= 1'b0;
            o_rd_eop  <= 1'b0;
        end else begin
            o_rd_vld <= o_q_pop || sending_q;
            o_rd_sop <= o_q_pop;
            o_rd_eop <= last_word;
            if (o_q_pop) begin
                sending_q <= 1'b1;
            end else if (last_word) begin
                sending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (o_q_pop || sending_q) begin
            o_rd_data <= rd_hdr.raw;
        end
        if (o_q_pop) begin
            slot_q <= i_q_slot;
            len_q  <= rd_hdr.hdr.len;   // Length from the stored header
            idx_q  <= pqs_pkg::WORD_W'(1);
        end else begin
            idx_q  <= idx_q + 1'b1;
        end
    end

    // A new packet starts only after an idle cycle or the previous eop
    a_sop_after_idle : assert property (@(posedge clk_in) disable iff (!rst_n_in)
        o_rd_sop |-> (!$past(o_rd_vld) || $past(o_rd_eop)));

endmodule

/* src/packet_switch.sv */
module packet_switch #(
    parameter  int P_PORT_NUM = pqs_pkg::PORT_NUM,
    parameter  int P_SLOT_NUM = pqs_pkg::SLOT_NUM,
    localparam int SW         = $clog2(P_SLOT_NUM)
) (
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  logic [P_PORT_NUM-1:0] i_wr_vld,
    input  logic [P_PORT_NUM-1:0] i_wr_sop,
    input  logic [P_PORT_NUM-1:0] i_wr_eop,
    input  pqs_pkg::data_t        i_wr_data [P_PORT_NUM-1:0],
    output logic [P_PORT_NUM-1:0] o_rd_vld,
    output logic [P_PORT_NUM-1:0] o_rd_sop,
    output logic [P_PORT_NUM-1:0] o_rd_eop,
    output pqs_pkg::data_t        o_rd_data [P_PORT_NUM-1:0],
    output logic                  o_full,
    output logic [P_PORT_NUM-1:0] o_drop
);

    // ========================================================================
    // Decode to buffer
    // ========================================================================
    logic [P_PORT_NUM-1:0]      alloc_req;
    logic [P_PORT_NUM-1:0]      alloc_ok;
    logic [SW-1:0]              alloc_slot  [P_PORT_NUM-1:0];
    logic [P_PORT_NUM-1:0]      wr_en;
    logic [SW-1:0]              wr_slot     [P_PORT_NUM-1:0];
    logic [pqs_pkg::WORD_W-1:0] wr_idx      [P_PORT_NUM-1:0];
    pqs_pkg::data_t             wr_data     [P_PORT_NUM-1:0];
    logic [P_PORT_NUM-1:0]      commit;
    logic [SW-1:0]              commit_slot [P_PORT_NUM-1:0];
    logic [pqs_pkg::PORT_W-1:0] commit_dest [P_PORT_NUM-1:0];
    logic [P_PORT_NUM-1:0]      abort;
    logic [SW-1:0]              abort_slot  [P_PORT_NUM-1:0];

    // Buffer to output
    logic [P_PORT_NUM-1:0]      q_vld;
    logic [SW-1:0]              q_slot      [P_PORT_NUM-1:0];
    logic [P_PORT_NUM-1:0]      q_pop;
    logic [SW-1:0]              rd_slot     [P_PORT_NUM-1:0];
    logic [pqs_pkg::WORD_W-1:0] rd_idx      [P_PORT_NUM-1:0];
    pqs_pkg::data_t             rd_word     [P_PORT_NUM-1:0];
    logic [P_PORT_NUM-1:0]      release_vld;
    logic [SW-1:0]              release_slot [P_PORT_NUM-1:0];

    for (genvar i = 0; i < P_PORT_NUM; i++) begin : g_in
        pkt_decode #(
            .P_SLOT_NUM (P_SLOT_NUM)
        ) u_decode (
            .clk_in        (clk_in        ),
            .rst_n_in      (rst_n_in      ),
            .i_wr_vld      (i_wr_vld   [i]),
            .i_wr_sop      (i_wr_sop   [i]),
            .i_wr_eop      (i_wr_eop   [i]),
            .i_wr_data     (i_wr_data  [i]),
            .i_alloc_ok    (alloc_ok   [i]),
            .i_alloc_slot  (alloc_slot [i]),
            .o_alloc_req   (alloc_req  [i]),
            .o_wr_en       (wr_en      [i]),
            .o_wr_slot     (wr_slot    [i]),
            .o_wr_idx      (wr_idx     [i]),
            .o_wr_data     (wr_data    [i]),
            .o_commit      (commit     [i]),
            .o_commit_slot (commit_slot[i]),
            .o_commit_dest (commit_dest[i]),
            .o_abort       (abort      [i]),
            .o_abort_slot  (abort_slot [i]),
            .o_drop        (o_drop     [i])
        );
    end

    slot_buffer #(
        .P_PORT_NUM (P_PORT_NUM),
        .P_SLOT_NUM (P_SLOT_NUM)
    ) u_buffer (
        .clk_in         (clk_in      ),
        .rst_n_in       (rst_n_in    ),
        .i_alloc_req    (alloc_req   ),
        .o_alloc_ok     (alloc_ok    ),
        .o_alloc_slot   (alloc_slot  ),
        .i_wr_en        (wr_en       ),
        .i_wr_slot      (wr_slot     ),
        .i_wr_idx       (wr_idx      ),
        .i_wr_data      (wr_data     ),
        .i_commit       (commit      ),
        .i_commit_slot  (commit_slot ),
        .i_commit_dest  (commit_dest ),
        .i_abort        (abort       ),
        .i_abort_slot   (abort_slot  ),
        .o_q_vld        (q_vld       ),
        .o_q_slot       (q_slot      ),
        .i_q_pop        (q_pop       ),
        .i_rd_slot      (rd_slot     ),
        .i_rd_idx       (rd_idx      ),
        .o_rd_word      (rd_word     ),
        .i_release      (release_vld ),
        .i_release_slot (release_slot),
        .o_full         (o_full      )
    );

    for (genvar o = 0; o < P_PORT_NUM; o++) begin : g_out
        port_output #(
            .P_SLOT_NUM (P_SLOT_NUM)
        ) u_output (
            .clk_in         (clk_in         ),
            .rst_n_in       (rst_n_in       ),
            .i_q_vld        (q_vld       [o]),
            .i_q_slot       (q_slot      [o]),
            .i_rd_word      (rd_word     [o]),
            .o_q_pop        (q_pop       [o]),
            .o_rd_slot      (rd_slot     [o]),
            .o_rd_idx       (rd_idx      [o]),
            .o_release      (release_vld [o]),
            .o_release_slot (release_slot[o]),
            .o_rd_vld       (o_rd_vld    [o]),
            .o_rd_sop       (o_rd_sop    [o]),
            .o_rd_eop       (o_rd_eop    [o]),
            .o_rd_data      (o_rd_data   [o])
        );
    end

endmodule

/* sim/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ============================================================================
// Stimulus
// ============================================================================
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Stages one packet on input src, with eop on payload word n_pay
task automatic make_pkt(input int src, input int dest, input int len, input int n_pay,
                        input bit accepted);
    pqs_pkg::hdr_word_u hdr;
    pqs_pkg::data_t     word;
    hdr.raw      = next_rand();          // Random tag
    hdr.hdr.dest = pqs_pkg::PORT_W'(dest);
    hdr.hdr.len  = pqs_pkg::LEN_W'(len);
    stage_q[src].push_back({1'b1, 1'b0, hdr.raw});
    if (accepted) begin
        exp_q[dest].push_back({1'b1, 1'b0, hdr.raw});
    end else begin
        drop_left[src]++;
    end
    for (int k = 1; k <= n_pay; k++) begin
        word = next_rand();
        stage_q[src].push_back({1'b0, k == n_pay, word});
        if (accepted) begin
            exp_q[dest].push_back({1'b0, k == n_pay, word});
        end
    end
endtask

task automatic drive_input(input int k);
    logic [33:0] ent;
    while (stage_q[k].size() != 0) begin
        ent = stage_q[k].pop_front();
        @(negedge clk_in);
        wr_vld[k]  = 1'b1;
        wr_sop[k]  = ent[33];
        wr_eop[k]  = ent[32];
        wr_data[k] = ent[31:0];
        words_sent++;
    end
    @(negedge clk_in);
    wr_vld[k] = 1'b0;
    wr_sop[k] = 1'b0;
    wr_eop[k] = 1'b0;
endtask

task automatic send_staged();
    fork
        drive_input(0);
        drive_input(1);
        drive_input(2);
        drive_input(3);
    join
endtask

function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < NP; i++) begin
        n += exp_q[i].size() + drop_left[i];
    end
    return n;
endfunction

task automatic wait_drain();
    while (pending() != 0) begin
        @(negedge clk_in);
    end
endtask

// ============================================================================
// Checks
// ============================================================================
task automatic check_word(input pqs_pkg::data_t got, input pqs_pkg::data_t want,
                          input string name);
    if (got !== want) begin
        fail_stop($sformatf("Mismatch at %0d ns: %s is 0x%08h, expected 0x%08h",
                            $time, name, got, want));
    end
endtask

task automatic check_flag(input logic got, input logic want, input string name);
    if (got !== want) begin
        fail_stop($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                            $time, name, got, want));
    end
endtask

task automatic check_output(input int o);
    logic [33:0] want;
    if (exp_q[o].size() == 0) begin
        fail_stop($sformatf("Output %0d sent word 0x%08h that no packet accounts for",
                            o, rd_data[o]));
    end else begin
        want = exp_q[o].pop_front();
        check_word(rd_data[o], want[31:0], $sformatf("o_rd_data[%0d]", o));
        check_flag(rd_sop[o], want[33], $sformatf("o_rd_sop[%0d]", o));
        check_flag(rd_eop[o], want[32], $sformatf("o_rd_eop[%0d]", o));
    end
endtask

// From the next sop on output o, n_words must follow with no idle cycle
task automatic check_no_gap(input int o, input int n_words);
    while (rd_sop[o] !== 1'b1) begin
        @(negedge clk_in);
    end
    for (int k = 1; k < n_words; k++) begin
        @(negedge clk_in);
        check_flag(rd_vld[o], 1'b1, $sformatf("o_rd_vld[%0d]", o));
    end
endtask

task automatic check_drops();
    for (int i = 0; i < NP; i++) begin
        if (drop[i] && drop_left[i] == 0) begin
            fail_stop($sformatf("Input %0d strobed o_drop for a packet that should pass", i));
        end else if (drop[i]) begin
            drop_left[i]--;
        end
    end
endtask

task automatic check_reset_state();
    for (int i = 0; i < NP; i++) begin
        check_flag(rd_vld[i], 1'b0, $sformatf("o_rd_vld[%0d]", i));
        check_flag(rd_sop[i], 1'b0, $sformatf("o_rd_sop[%0d]", i));
        check_flag(rd_eop[i], 1'b0, $sformatf("o_rd_eop[%0d]", i));
        check_flag(drop[i], 1'b0, $sformatf("o_drop[%0d]", i));
    end
    check_flag(full, 1'b0, "o_full");
endtask

// ============================================================================
// Directed tests
// ============================================================================
task automatic test_single();
    make_pkt(0, 2, 5, 5, 1'b1);
    send_staged();
    wait_drain();
endtask

task automatic test_all_inputs();
    for (int i = 0; i < NP; i++) begin
        make_pkt(i, NP - 1 - i, i + 2, i + 2, 1'b1);    // Distinct outputs
    end
    send_staged();
    wait_drain();
endtask

task automatic test_shared_dest();
    for (int r = 0; r < 2; r++) begin
        for (int i = 0; i < 3; i++) begin
            make_pkt(i, 1, 3 + 2 * r, 3 + 2 * r, 1'b1);  // Equal lengths, same eop cycle
        end
        send_staged();
        check_no_gap(1, 3 * (4 + 2 * r));               // Three packets back to back
        wait_drain();
        check_flag(full, 1'b0, "o_full");
    end
endtask

task automatic test_full_buffer();
    full_seen = 1'b0;
    for (int i = 0; i < NP; i++) begin
        make_pkt(i, 0, 7, 7, 1'b1);     // Slots 0 to 3
    end
    for (int i = 0; i < NP; i++) begin
        make_pkt(i, 0, 1, 1, 1'b1);     // Slots 4 to 7
    end
    for (int i = 0; i < NP; i++) begin
        make_pkt(i, 0, 1, 1, 1'b0);     // No slot left
    end
    send_staged();
    wait_drain();
    check_flag(full_seen, 1'b1, "o_full seen high");
    check_flag(full, 1'b0, "o_full");
endtask

task automatic test_malformed();
    make_pkt(3, 0, 3, 2, 1'b0);         // eop one word early
    make_pkt(3, 0, 2, 3, 1'b0);         // eop one word late
    stage_q[3].push_back({1'b0, 1'b0, next_rand()});
    drop_left[3]++;                     // Word with no sop
    make_pkt(3, 0, 4, 4, 1'b1);
    send_staged();
    wait_drain();
    check_flag(full, 1'b0, "o_full");
endtask

`endif

/* sim/tb_packet_switch.sv */
module tb_packet_switch;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NP = pqs_pkg::PORT_NUM;

    logic           clk_in;
    logic           rst_n_in;
    logic [NP-1:0]  wr_vld;
    logic [NP-1:0]  wr_sop;
    logic [NP-1:0]  wr_eop;
    pqs_pkg::data_t wr_data [NP-1:0];
    logic [NP-1:0]  rd_vld;
    logic [NP-1:0]  rd_sop;
    logic [NP-1:0]  rd_eop;
    pqs_pkg::data_t rd_data [NP-1:0];
    logic           full;
    logic [NP-1:0]  drop;

    logic [31:0]    lcg_state;
    int             cycle_cnt  = 0;
    int             words_sent = 0;
    logic           full_seen;          // Sticky copy of o_full
    int             drop_left [NP];     // Drops still owed per input
    logic [33:0]    stage_q   [NP][$];  // {sop, eop, word} waiting to go in
    logic [33:0]    exp_q     [NP][$];  // {sop, eop, word} due on each output

    `include "tb_tasks.svh"

    packet_switch #(
        .P_PORT_NUM (pqs_pkg::PORT_NUM),
        .P_SLOT_NUM (pqs_pkg::SLOT_NUM)
    ) u_dut (
        .clk_in    (clk_in  ),
        .rst_n_in  (rst_n_in),
        .i_wr_vld  (wr_vld  ),
        .i_wr_sop  (wr_sop  ),
        .i_wr_eop  (wr_eop  ),
        .i_wr_data (wr_data ),
        .o_rd_vld  (rd_vld  ),
        .o_rd_sop  (rd_sop  ),
        .o_rd_eop  (rd_eop  ),
        .o_rd_data (rd_data ),
        .o_full    (full    ),
        .o_drop    (drop    )
    );

    always #2 clk_in = ~clk_in;     // 4 ns period

    // ========================================================================
    // Run limit, grows with the traffic sent so far
    // ========================================================================
    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > words_sent * 4 + 200) begin
            fail_stop($sformatf("Timeout after %0d cycles with %0d words sent",
                                cycle_cnt, words_sent));
        end
    end

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk_in) begin
        if (rst_n_in) begin
            for (int o = 0; o < NP; o++) begin
                if (rd_vld[o]) begin
                    check_output(o);
                end else begin
                    check_flag(rd_sop[o], 1'b0, $sformatf("o_rd_sop[%0d]", o));
                    check_flag(rd_eop[o], 1'b0, $sformatf("o_rd_eop[%0d]", o));
                end
            end
            check_drops();
            if (full) begin
                full_seen = 1'b1;
            end
        end
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    initial begin
        clk_in    = 1'b0;
        rst_n_in  = 1'b0;
        wr_vld    = '0;
        wr_sop    = '0;
        wr_eop    = '0;
        lcg_state = 32'h1876;
        full_seen = 1'b0;
        for (int i = 0; i < NP; i++) begin
            wr_data[i]   = '0;
            drop_left[i] = 0;
        end
        repeat (10) @(posedge clk_in);
        @(negedge clk_in);
        rst_n_in = 1'b1;

        check_reset_state();
        test_single();
        test_all_inputs();
        test_shared_dest();
        test_full_buffer();
        test_malformed();

        repeat (20) @(negedge clk_in);     // Let any stray output surface
        if (pending() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_stop($sformatf("%0d expected words or drops never arrived", pending()));
        end
    end

endmodule

/* all.f */
+incdir+sim
src/pqs_pkg.sv
src/pkt_decode.sv
src/slot_buffer.sv
src/port_output.sv
src/packet_switch.sv
sim/tb_packet_switch.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_packet_switch
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
